/* source/trace_pkg.sv */
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Sequence numbers wrap at 64, with at most five in flight
    localparam int SEQ_W = 6;

    // Cycle stamps wrap around
    localparam int CYCLE_W = 16;

    // Statistics counters saturate
    localparam int COUNT_W = 16;

    localparam int NUM_STAGES = 5;

    // Stage bit positions, fetch in bit 0
    localparam int STG_IF  = 0;
    localparam int STG_ID  = 1;
    localparam int STG_EX  = 2;
    localparam int STG_MEM = 3;
    localparam int STG_WB  = 4;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [SEQ_W-1:0]      seq_id_t;
    typedef logic [CYCLE_W-1:0]    cycle_t;
    typedef logic [COUNT_W-1:0]    count_t;
    typedef logic [NUM_STAGES-1:0] stage_mask_t;

    typedef enum logic [1:0] {
        TRACE_IDLE,
        TRACE_RUN,
        TRACE_DRAIN
    } trace_state_t;

endpackage

`default_nettype wire

/* source/trace_counters.sv */
`default_nettype none
`timescale 1ns/1ps

module trace_counters (
    input  logic              clk,
    input  logic              rst,
    input  logic              stats_clear,
    input  logic              stall_hold,
    input  logic [1:0]        squash_count,
    output trace_pkg::cycle_t now,
    output trace_pkg::count_t stall_cycles,
    output trace_pkg::count_t squashed_count
);

    import trace_pkg::*;

    // One extra bit to catch overflow of the squash total
    logic [COUNT_W:0] squash_sum;

    assign squash_sum = {1'b0, squashed_count} + {{(COUNT_W-1){1'b0}}, squash_count};

    ////////////////////////////////////////////////////////////
    // Cycle stamp
    ////////////////////////////////////////////////////////////

    // Zero in the first cycle after reset, then free running
    always_ff @(posedge clk) begin
        if (!rst) begin
            now <= '0;
        end else begin
            now <= now + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Statistics
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stall_cycles   <= '0;
            squashed_count <= '0;
        end else if (stats_clear) begin
            stall_cycles   <= '0;
            squashed_count <= '0;
        end else begin
            // Both stick at all ones
            if (stall_hold && (stall_cycles != '1)) begin
                stall_cycles <= stall_cycles + 1'b1;
            end
            if (squash_sum[COUNT_W]) begin
                squashed_count <= '1;
            end else begin
                squashed_count <= squash_sum[COUNT_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/trace_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module trace_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic stop,
    input  logic empty,
    output logic fetch_allowed,
    output logic busy,
    output logic stats_clear
);

    import trace_pkg::*;

    trace_state_t state;
    trace_state_t state_next;

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            TRACE_IDLE: begin
                if (start) begin
                    state_next = TRACE_RUN;
                end
            end
            TRACE_RUN: begin
                // Start is ignored once running
                if (stop) begin
                    state_next = TRACE_DRAIN;
                end
            end
            TRACE_DRAIN: begin
                // Wait until the last tracked instruction has left write-back
                if (empty) begin
                    state_next = TRACE_IDLE;
                end
            end
            default: begin
                state_next = TRACE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= TRACE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    assign fetch_allowed = (state == TRACE_RUN);
    assign busy          = (state != TRACE_IDLE);

    // Statistics restart with each new run
    assign stats_clear = (state == TRACE_IDLE) && start;

endmodule

`default_nettype wire

/* source/stage_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

module stage_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_allowed,
    input  logic                   stall,
    input  logic                   flush,
    output trace_pkg::stage_mask_t stage_valid,
    output trace_pkg::stage_mask_t stage_enter,
    output trace_pkg::seq_id_t     if_id,
    output trace_pkg::seq_id_t     id_id,
    output trace_pkg::seq_id_t     ex_id,
    output trace_pkg::seq_id_t     mem_id,
    output trace_pkg::seq_id_t     wb_id,
    output logic                   empty,
    output logic                   stall_hold,
    output logic [1:0]             squash_count
);

    import trace_pkg::*;

    seq_id_t     next_seq;
    logic        advance;
    logic        held;
    stage_mask_t hold_mask;

    // Flush wins over stall
    assign advance = !flush && !stall;

    ////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_valid <= '0;
            held        <= 1'b0;
            next_seq    <= '0;
        end else begin
            // Memory and write-back always move on
            stage_valid[STG_WB]  <= stage_valid[STG_MEM];
            stage_valid[STG_MEM] <= stage_valid[STG_EX];
            held                 <= 1'b0;
            if (flush) begin
                stage_valid[STG_EX] <= 1'b0;
                stage_valid[STG_ID] <= 1'b0;
                stage_valid[STG_IF] <= 1'b0;
            end else if (stall) begin
                // Fetch and decode keep their contents
                stage_valid[STG_EX] <= 1'b0;
                held                <= 1'b1;
            end else begin
                stage_valid[STG_EX] <= stage_valid[STG_ID];
                stage_valid[STG_ID] <= stage_valid[STG_IF];
                stage_valid[STG_IF] <= fetch_allowed;
                if (fetch_allowed) begin
                    next_seq <= next_seq + 1'b1;
                end
            end
        end
    end

    // Sequence numbers follow the valid bits, bubbles keep stale ids
    always_ff @(posedge clk) begin
        wb_id  <= mem_id;
        mem_id <= ex_id;
        if (advance) begin
            ex_id <= id_id;
            id_id <= if_id;
            if_id <= next_seq;
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry mask and hazard reporting
    ////////////////////////////////////////////////////////////

    always_comb begin
        hold_mask         = '0;
        hold_mask[STG_IF] = held;
        hold_mask[STG_ID] = held;
    end

    // A stage holding through a stall is not a new entry
    assign stage_enter = stage_valid & ~hold_mask;

    assign empty = (stage_valid == '0);

    assign stall_hold = stall && !flush && stage_valid[STG_ID];

    assign squash_count = flush ? ({1'b0, stage_valid[STG_IF]} + {1'b0, stage_valid[STG_ID]})
                                : 2'd0;

endmodule

`default_nettype wire

/* source/stamp_table.sv */
`default_nettype none
`timescale 1ns/1ps

module stamp_table (
    input  logic                   clk,
    input  logic                   rst,
    input  trace_pkg::cycle_t      now,
    input  trace_pkg::stage_mask_t stage_enter,
    input  trace_pkg::seq_id_t     if_id,
    input  trace_pkg::seq_id_t     id_id,
    input  trace_pkg::seq_id_t     ex_id,
    input  trace_pkg::seq_id_t     mem_id,
    input  trace_pkg::seq_id_t     wb_id,
    output logic                   retire_valid,
    output trace_pkg::seq_id_t     retire_id,
    output trace_pkg::cycle_t      retire_if_stamp,
    output trace_pkg::cycle_t      retire_id_stamp,
    output trace_pkg::cycle_t      retire_ex_stamp,
    output trace_pkg::cycle_t      retire_mem_stamp,
    output trace_pkg::cycle_t      retire_wb_stamp
);

    import trace_pkg::*;

    // One entry per sequence number
    cycle_t if_stamp  [2**SEQ_W];
    cycle_t id_stamp  [2**SEQ_W];
    cycle_t ex_stamp  [2**SEQ_W];
    cycle_t mem_stamp [2**SEQ_W];

    ////////////////////////////////////////////////////////////
    // Stamp capture on stage entry
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stage_enter[STG_IF]) begin
            if_stamp[if_id] <= now;
        end
        if (stage_enter[STG_ID]) begin
            id_stamp[id_id] <= now;
        end
        if (stage_enter[STG_EX]) begin
            ex_stamp[ex_id] <= now;
        end
        if (stage_enter[STG_MEM]) begin
            mem_stamp[mem_id] <= now;
        end
    end

    ////////////////////////////////////////////////////////////
    // Retire record
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= stage_enter[STG_WB];
        end
    end

    // Write-back stamp is taken live
    always_ff @(posedge clk) begin
        if (stage_enter[STG_WB]) begin
            retire_id        <= wb_id;
            retire_if_stamp  <= if_stamp[wb_id];
            retire_id_stamp  <= id_stamp[wb_id];
            retire_ex_stamp  <= ex_stamp[wb_id];
            retire_mem_stamp <= mem_stamp[wb_id];
            retire_wb_stamp  <= now;
        end
    end

endmodule

`default_nettype wire

/* source/pipeline_trace_top.sv */
`default_nettype none
`timescale 1ns/1ps

module pipeline_trace_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              stop,
    input  logic              stall,
    input  logic              flush,
    output logic              busy,
    output logic              retire_valid,
    output trace_pkg::seq_id_t retire_id,
    output trace_pkg::cycle_t retire_if_stamp,
    output trace_pkg::cycle_t retire_id_stamp,
    output trace_pkg::cycle_t retire_ex_stamp,
    output trace_pkg::cycle_t retire_mem_stamp,
    output trace_pkg::cycle_t retire_wb_stamp,
    output trace_pkg::count_t stall_cycles,
    output trace_pkg::count_t squashed_count
);

    import trace_pkg::*;

    logic        fetch_allowed;
    logic        stats_clear;
    logic        empty;
    logic        stall_hold;
    logic [1:0]  squash_count;
    cycle_t      now;
    stage_mask_t stage_valid;
    stage_mask_t stage_enter;
    seq_id_t     if_id;
    seq_id_t     id_id;
    seq_id_t     ex_id;
    seq_id_t     mem_id;
    seq_id_t     wb_id;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    trace_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .stop          (stop),
        .empty         (empty),
        .fetch_allowed (fetch_allowed),
        .busy          (busy),
        .stats_clear   (stats_clear)
    );

    trace_counters u_counters (
        .clk            (clk),
        .rst            (rst),
        .stats_clear    (stats_clear),
        .stall_hold     (stall_hold),
        .squash_count   (squash_count),
        .now            (now),
        .stall_cycles   (stall_cycles),
        .squashed_count (squashed_count)
    );

    ////////////////////////////////////////////////////////////
    // Tracking
    ////////////////////////////////////////////////////////////

    stage_tracker u_tracker (
        .clk           (clk),
        .rst           (rst),
        .fetch_allowed (fetch_allowed),
        .stall         (stall),
        .flush         (flush),
        .stage_valid   (stage_valid),
        .stage_enter   (stage_enter),
        .if_id         (if_id),
        .id_id         (id_id),
        .ex_id         (ex_id),
        .mem_id        (mem_id),
        .wb_id         (wb_id),
        .empty         (empty),
        .stall_hold    (stall_hold),
        .squash_count  (squash_count)
    );

    stamp_table u_stamps (
        .clk              (clk),
        .rst              (rst),
        .now              (now),
        .stage_enter      (stage_enter),
        .if_id            (if_id),
        .id_id            (id_id),
        .ex_id            (ex_id),
        .mem_id           (mem_id),
        .wb_id            (wb_id),
        .retire_valid     (retire_valid),
        .retire_id        (retire_id),
        .retire_if_stamp  (retire_if_stamp),
        .retire_id_stamp  (retire_id_stamp),
        .retire_ex_stamp  (retire_ex_stamp),
        .retire_mem_stamp (retire_mem_stamp),
        .retire_wb_stamp  (retire_wb_stamp)
    );

endmodule

`default_nettype wire

/* tb/pipeline_trace_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module pipeline_trace_assert (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   busy,
    input  logic                   retire_valid,
    input  trace_pkg::cycle_t      retire_if_stamp,
    input  trace_pkg::cycle_t      retire_id_stamp,
    input  trace_pkg::cycle_t      retire_ex_stamp,
    input  trace_pkg::cycle_t      retire_mem_stamp,
    input  trace_pkg::cycle_t      retire_wb_stamp,
    input  trace_pkg::stage_mask_t stage_valid
);

    // Read by the testbench at the end of the run
    int unsigned assert_errors = 0;

    // Nothing retires after a reset edge
    retire_quiet_in_reset: assert property (@(posedge clk) !rst |=> !retire_valid)
        else begin
            assert_errors++;
            $error("retire_valid high after a reset edge");
        end

    // Stage stamps follow pipeline order
    stamps_increase: assert property (@(posedge clk) disable iff (!rst)
        retire_valid |-> (retire_if_stamp < retire_id_stamp)
                      && (retire_id_stamp < retire_ex_stamp)
                      && (retire_ex_stamp < retire_mem_stamp)
                      && (retire_mem_stamp < retire_wb_stamp))
        else begin
            assert_errors++;
            $error("retire stamps not strictly increasing");
        end

    // Drain is over only with an empty pipeline and no record in flight
    busy_falls_when_empty: assert property (@(posedge clk) disable iff (!rst)
        $fell(busy) |-> (stage_valid == '0) && !retire_valid)
        else begin
            assert_errors++;
            $error("busy fell with a retire still pending");
        end

endmodule

`default_nettype wire

/* tb/pipeline_trace_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module pipeline_trace_tb;

    import trace_pkg::*;

    localparam logic [31:0] SEED = 32'h1788_9d4f;
    localparam int RESET_CYCLES   = 8;
    localparam int IDLE_CYCLES    = 20;
    localparam int CLEAN_CYCLES   = 300;
    localparam int RANDOM_CYCLES  = 700;
    localparam int RESTART_CYCLES = 600;
    // Allowance per stop for the drain and the quiet cycles after it
    localparam int DRAIN_CYCLES   = 100;
    localparam int SETTLE_CYCLES  = 10;
    localparam int PLANNED_CYCLES = RESET_CYCLES + IDLE_CYCLES + CLEAN_CYCLES
                                  + RANDOM_CYCLES + RESTART_CYCLES + 3 * DRAIN_CYCLES;
    localparam int CYCLE_LIMIT    = PLANNED_CYCLES + 500;
    localparam int STALL_PCT = 20;
    localparam int FLUSH_PCT = 7;
    localparam int CTRL_PCT  = 2;

    logic    clk;
    logic    rst;
    logic    start;
    logic    stop;
    logic    stall;
    logic    flush;
    logic    busy;
    logic    retire_valid;
    seq_id_t retire_id;
    cycle_t  retire_if_stamp;
    cycle_t  retire_id_stamp;
    cycle_t  retire_ex_stamp;
    cycle_t  retire_mem_stamp;
    cycle_t  retire_wb_stamp;
    count_t  stall_cycles;
    count_t  squashed_count;

    logic [31:0] rng;
    int          errors;
    int          retires_seen;
    int          cycle_count = 0;
    logic        clean_run;
    seq_id_t     last_id;

    // Reference model state
    trace_state_t m_state;
    logic         m_valid [NUM_STAGES];
    seq_id_t      m_id [NUM_STAGES];
    seq_id_t      m_next;
    cycle_t       m_cycle;
    cycle_t       m_stamp [2**SEQ_W][NUM_STAGES];
    logic         m_squashed_ids [2**SEQ_W];
    logic         m_retire;
    seq_id_t      m_ret_id;
    cycle_t       m_ret_stamp [NUM_STAGES];
    count_t       m_stalls;
    count_t       m_squashed;

    pipeline_trace_top UUT (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .stop             (stop),
        .stall            (stall),
        .flush            (flush),
        .busy             (busy),
        .retire_valid     (retire_valid),
        .retire_id        (retire_id),
        .retire_if_stamp  (retire_if_stamp),
        .retire_id_stamp  (retire_id_stamp),
        .retire_ex_stamp  (retire_ex_stamp),
        .retire_mem_stamp (retire_mem_stamp),
        .retire_wb_stamp  (retire_wb_stamp),
        .stall_cycles     (stall_cycles),
        .squashed_count   (squashed_count)
    );

    bind pipeline_trace_top pipeline_trace_assert u_assert (
        .clk              (clk),
        .rst              (rst),
        .busy             (busy),
        .retire_valid     (retire_valid),
        .retire_if_stamp  (retire_if_stamp),
        .retire_id_stamp  (retire_id_stamp),
        .retire_ex_stamp  (retire_ex_stamp),
        .retire_mem_stamp (retire_mem_stamp),
        .retire_wb_stamp  (retire_wb_stamp),
        .stage_valid      (stage_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail at time %0t: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    task automatic model_reset();
        m_state  = TRACE_IDLE;
        m_next   = '0;
        m_cycle  = '0;
        m_retire = 1'b0;
        m_stalls   = '0;
        m_squashed = '0;
        for (int s = 0; s < NUM_STAGES; s++) begin
            m_valid[s] = 1'b0;
            m_id[s]    = '0;
        end
        for (int i = 0; i < 2**SEQ_W; i++) begin
            m_squashed_ids[i] = 1'b0;
        end
    endtask

    // One rising edge with the inputs held during the cycle before it
    task automatic model_edge();
        logic    old_valid [NUM_STAGES];
        seq_id_t old_id [NUM_STAGES];
        logic    was_empty;
        logic    fetch_ok;
        logic    clear;
        logic    hold;
        int      killed;
        int      sum;
        old_valid = m_valid;
        old_id    = m_id;
        was_empty = 1'b1;
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (old_valid[s]) begin
                was_empty = 1'b0;
            end
        end
        fetch_ok = (m_state == TRACE_RUN);
        clear    = (m_state == TRACE_IDLE) && start;

        // Write-back occupant is reported in the next cycle
        m_retire = old_valid[STG_WB];
        if (m_retire) begin
            m_ret_id = old_id[STG_WB];
            for (int s = 0; s < NUM_STAGES; s++) begin
                m_ret_stamp[s] = m_stamp[old_id[STG_WB]][s];
            end
        end

        m_valid[STG_WB]  = old_valid[STG_MEM];
        m_id[STG_WB]     = old_id[STG_MEM];
        m_valid[STG_MEM] = old_valid[STG_EX];
        m_id[STG_MEM]    = old_id[STG_EX];
        hold   = 1'b0;
        killed = 0;
        if (flush) begin
            killed = int'(old_valid[STG_IF]) + int'(old_valid[STG_ID]);
            if (old_valid[STG_IF]) begin
                m_squashed_ids[old_id[STG_IF]] = 1'b1;
            end
            if (old_valid[STG_ID]) begin
                m_squashed_ids[old_id[STG_ID]] = 1'b1;
            end
            m_valid[STG_EX] = 1'b0;
            m_valid[STG_ID] = 1'b0;
            m_valid[STG_IF] = 1'b0;
        end else if (stall) begin
            m_valid[STG_EX] = 1'b0;
            hold = 1'b1;
        end else begin
            m_valid[STG_EX] = old_valid[STG_ID];
            m_id[STG_EX]    = old_id[STG_ID];
            m_valid[STG_ID] = old_valid[STG_IF];
            m_id[STG_ID]    = old_id[STG_IF];
            m_valid[STG_IF] = fetch_ok;
            if (fetch_ok) begin
                m_id[STG_IF] = m_next;
                m_squashed_ids[m_next] = 1'b0;
                m_next = m_next + 1'b1;
            end
        end

        // Held stages keep the stamp of their first entry
        m_cycle = m_cycle + 1'b1;
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (m_valid[s] && !(hold && s <= STG_ID)) begin
                m_stamp[m_id[s]][s] = m_cycle;
            end
        end

        if (clear) begin
            m_stalls   = '0;
            m_squashed = '0;
        end else begin
            if (stall && !flush && old_valid[STG_ID] && m_stalls != '1) begin
                m_stalls = m_stalls + 1'b1;
            end
            sum = int'(m_squashed) + killed;
            m_squashed = (sum > (2**COUNT_W) - 1) ? '1 : count_t'(sum);
        end

        case (m_state)
            TRACE_IDLE: begin
                if (start) begin
                    m_state = TRACE_RUN;
                end
            end
            TRACE_RUN: begin
                if (stop) begin
                    m_state = TRACE_DRAIN;
                end
            end
            TRACE_DRAIN: begin
                if (was_empty) begin
                    m_state = TRACE_IDLE;
                end
            end
            default: begin
                m_state = TRACE_IDLE;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_outputs();
        cycle_t got [NUM_STAGES];
        cycle_t base;
        got[STG_IF]  = retire_if_stamp;
        got[STG_ID]  = retire_id_stamp;
        got[STG_EX]  = retire_ex_stamp;
        got[STG_MEM] = retire_mem_stamp;
        got[STG_WB]  = retire_wb_stamp;
        if (busy !== (m_state != TRACE_IDLE)) begin
            report_mismatch($sformatf("busy is %b, model state %s", busy, m_state.name()));
        end
        if (stall_cycles !== m_stalls) begin
            report_mismatch($sformatf("stall_cycles %0d, expected %0d", stall_cycles, m_stalls));
        end
        if (squashed_count !== m_squashed) begin
            report_mismatch($sformatf("squashed_count %0d, expected %0d",
                                      squashed_count, m_squashed));
        end
        if (retire_valid === 1'b1 && m_squashed_ids[retire_id] === 1'b1) begin
            report_problem($sformatf("Squashed instruction %0d retired at time %0t",
                                     retire_id, $time));
        end
        if (retire_valid === 1'b1 && !m_retire) begin
            report_problem($sformatf("Extra retire record for sequence number %0d at time %0t",
                                     retire_id, $time));
        end else if (retire_valid !== 1'b1 && m_retire) begin
            report_problem($sformatf("Missing retire record for sequence number %0d at time %0t",
                                     m_ret_id, $time));
        end else if (m_retire) begin
            retires_seen++;
            if (retire_id !== m_ret_id) begin
                report_mismatch($sformatf("retire_id %0d, expected %0d", retire_id, m_ret_id));
            end
            for (int s = 0; s < NUM_STAGES; s++) begin
                if (got[s] !== m_ret_stamp[s]) begin
                    report_mismatch($sformatf("stage %0d stamp of %0d is %0d, expected %0d",
                                              s, m_ret_id, got[s], m_ret_stamp[s]));
                end
            end
            if (clean_run) begin
                // Hazard-free record retires five cycles after fetch
                base = m_cycle - cycle_t'(NUM_STAGES);
                if (retire_id !== seq_id_t'(last_id + 1'b1)) begin
                    report_mismatch($sformatf("retire_id %0d out of order after %0d",
                                              retire_id, last_id));
                end
                for (int s = 0; s < NUM_STAGES; s++) begin
                    if (got[s] !== base + cycle_t'(s)) begin
                        report_mismatch($sformatf("clean stage %0d stamp %0d, expected %0d",
                                                  s, got[s], base + cycle_t'(s)));
                    end
                end
            end
            last_id = retire_id;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic step(input int stall_pct, input int flush_pct, input int ctrl_pct,
                        input logic want_start, input logic want_stop);
        int unsigned roll;
        @(posedge clk);
        #2;
        model_edge();
        check_outputs();
        rng   = xorshift32(rng);
        stall = (rng % 100) < stall_pct;
        rng   = xorshift32(rng);
        flush = (rng % 100) < flush_pct;
        rng   = xorshift32(rng);
        roll  = rng % 100;
        start = want_start || (roll < ctrl_pct);
        stop  = want_stop || (!start && roll < 2 * ctrl_pct);
    endtask

    // Stop and let the pipeline drain before watching for stray records
    task automatic drain(input int stall_pct, input int flush_pct);
        step(stall_pct, flush_pct, 0, 1'b0, 1'b1);
        while (busy || m_state != TRACE_IDLE) begin
            step(stall_pct, flush_pct, 0, 1'b0, 1'b0);
        end
        repeat (SETTLE_CYCLES) step(0, 0, 0, 1'b0, 1'b0);
    endtask

    initial begin
        int total;
        clk   = 1'b0;
        rst   = 1'b0;
        start = 1'b0;
        stop  = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        rng   = SEED;
        errors       = 0;
        retires_seen = 0;
        clean_run    = 1'b0;
        last_id      = '1;
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;
        if (busy !== 1'b0 || retire_valid !== 1'b0 || stall_cycles !== '0
                || squashed_count !== '0) begin
            report_mismatch("outputs not cleared by reset");
        end

        // Hazards before any start must leave everything quiet
        repeat (IDLE_CYCLES) step(STALL_PCT, FLUSH_PCT, 0, 1'b0, 1'b0);

        clean_run = 1'b1;
        step(0, 0, 0, 1'b1, 1'b0);
        repeat (CLEAN_CYCLES) step(0, 0, 0, 1'b0, 1'b0);
        drain(0, 0);
        clean_run = 1'b0;

        step(STALL_PCT, FLUSH_PCT, 0, 1'b1, 1'b0);
        repeat (RANDOM_CYCLES) step(STALL_PCT, FLUSH_PCT, CTRL_PCT, 1'b0, 1'b0);
        drain(STALL_PCT, FLUSH_PCT);

        // Restart clears statistics while numbering carries on
        step(STALL_PCT, FLUSH_PCT, 0, 1'b1, 1'b0);
        repeat (RESTART_CYCLES) step(STALL_PCT, FLUSH_PCT, 0, 1'b0, 1'b0);
        drain(STALL_PCT, FLUSH_PCT);

        total = errors + UUT.u_assert.assert_errors;
        $display("Retires checked: %0d, check errors: %0d, assertion errors: %0d",
                 retires_seen, errors, UUT.u_assert.assert_errors);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/trace_pkg.sv
source/trace_counters.sv
source/trace_fsm.sv
source/stage_tracker.sv
source/stamp_table.sv
source/pipeline_trace_top.sv
tb/pipeline_trace_assert.sv
tb/pipeline_trace_tb.sv

/* Bender.yml */
package:
  name: pipeline_trace

sources:
  # Design, package first
  - files:
      - source/trace_pkg.sv
      - source/trace_counters.sv
      - source/trace_fsm.sv
      - source/stage_tracker.sv
      - source/stamp_table.sv
      - source/pipeline_trace_top.sv

  # Testbench
  - target: test
    files:
      - tb/pipeline_trace_assert.sv
      - tb/pipeline_trace_tb.sv
